// File: ifu_top.f
rtl/ifu_pkg.sv
rtl/ifu_bus_pkg.sv
rtl/ifu_ibusif.sv
rtl/ifu_ibuf.sv
rtl/ifu_ifctrl.sv
rtl/ifu_ifdp.sv
rtl/ifu_top.sv
testbench/tb_ifu_top.sv

// File: rtl/ifu_bus_pkg.sv
/*
 * Instruction bus definitions
 * AXI4-Lite read channel widths, response codes and bus FSM states
 */
`default_nettype none

package ifu_bus_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;

  // Unprivileged, secure, instruction access
  localparam logic [2:0] ARPROT_INST = 3'b100;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // One transaction at a time, so three states are enough
  typedef enum logic [1:0] {
    IBUS_IDLE = 2'b00,
    IBUS_ADDR = 2'b01,
    IBUS_DATA = 2'b10
  } ibus_state_e;

endpackage

`default_nettype wire

// File: rtl/ifu_ibuf.sv
/*
 * Instruction buffer
 * Small FIFO of fetched words with address and bus error flag
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_ibuf (
  input  logic                 forever_cpuclk,
  input  logic                 rst,
  input  logic                 iu_yy_xx_flush,
  input  logic                 resp_vld,
  input  ifu_pkg::inst_t       resp_data,
  input  ifu_pkg::fetch_addr_t resp_addr,
  input  logic                 resp_err,
  input  logic                 pop,
  output logic                 ibuf_room,
  output logic                 ibuf_vld,
  output ifu_pkg::inst_t       ibuf_inst,
  output ifu_pkg::fetch_addr_t ibuf_addr,
  output logic                 ibuf_err
);

  typedef logic [ifu_pkg::IBUF_PTR_W-1:0] ptr_t;
  typedef logic [ifu_pkg::IBUF_PTR_W:0]   cnt_t;

  ifu_pkg::inst_t       inst_mem [ifu_pkg::IBUF_DEPTH];
  ifu_pkg::fetch_addr_t addr_mem [ifu_pkg::IBUF_DEPTH];
  logic                 err_mem  [ifu_pkg::IBUF_DEPTH];

  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;
  logic pop_en;

  assign pop_en = pop && ibuf_vld;

  // ====================================================================
  // Pointers and occupancy
  // ====================================================================
  always_ff @(posedge forever_cpuclk) begin
    if (rst || iu_yy_xx_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (resp_vld) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      unique case ({resp_vld, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge forever_cpuclk) begin
    if (resp_vld) begin
      inst_mem[wr_ptr] <= resp_data;
      addr_mem[wr_ptr] <= resp_addr;
      err_mem[wr_ptr]  <= resp_err;
    end
  end

  // ====================================================================
  // Head and status
  // ====================================================================
  assign ibuf_vld  = (count != '0);
  // Two free slots, room for an in-flight word plus the next one
  assign ibuf_room = (count <= cnt_t'(ifu_pkg::IBUF_DEPTH - 2));

  assign ibuf_inst = inst_mem[rd_ptr];
  assign ibuf_addr = addr_mem[rd_ptr];
  assign ibuf_err  = err_mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/ifu_ibusif.sv
/*
 * Instruction bus interface
 * AXI4-Lite read master, one transaction per accepted fetch request
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_ibusif (
  input  logic                                 forever_cpuclk,
  input  logic                                 rst,
  input  logic                                 fetch_req,
  input  ifu_pkg::fetch_addr_t                 fetch_addr,
  input  logic                                 iu_yy_xx_flush,
  input  logic                                 arready,
  input  logic [ifu_bus_pkg::AXI_DATA_W-1:0]   rdata,
  input  ifu_bus_pkg::axi_resp_e               rresp,
  input  logic                                 rvalid,
  output logic                                 fetch_ack,
  output logic [ifu_bus_pkg::AXI_ADDR_W-1:0]   araddr,
  output logic [2:0]                           arprot,
  output logic                                 arvalid,
  output logic                                 rready,
  output logic                                 resp_vld,
  output ifu_pkg::inst_t                       resp_data,
  output ifu_pkg::fetch_addr_t                 resp_addr,
  output logic                                 resp_err,
  output logic                                 ifu_iu_ibus_idle
);

  ifu_bus_pkg::ibus_state_e state;
  ifu_pkg::fetch_addr_t     addr_q;
  logic                     discard_q;

  // ====================================================================
  // Bus FSM
  // ====================================================================
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      state     <= ifu_bus_pkg::IBUS_IDLE;
      discard_q <= 1'b0;
    end else begin
      unique case (state)
        ifu_bus_pkg::IBUS_IDLE: begin
          if (fetch_req) begin
            state     <= ifu_bus_pkg::IBUS_ADDR;
            discard_q <= 1'b0;
          end
        end
        ifu_bus_pkg::IBUS_ADDR: begin
          if (arready) begin
            state <= ifu_bus_pkg::IBUS_DATA;
          end
          if (iu_yy_xx_flush) begin
            discard_q <= 1'b1;
          end
        end
        ifu_bus_pkg::IBUS_DATA: begin
          if (rvalid) begin
            state <= ifu_bus_pkg::IBUS_IDLE;
          end
          if (iu_yy_xx_flush) begin
            discard_q <= 1'b1;
          end
        end
        default: state <= ifu_bus_pkg::IBUS_IDLE;
      endcase
    end
  end

  // Request address, kept to tag the response
  always_ff @(posedge forever_cpuclk) begin
    if (state == ifu_bus_pkg::IBUS_IDLE && fetch_req) begin
      addr_q <= fetch_addr;
    end
  end

  // ====================================================================
  // Outputs
  // ====================================================================
  assign fetch_ack        = (state == ifu_bus_pkg::IBUS_IDLE);
  assign ifu_iu_ibus_idle = (state == ifu_bus_pkg::IBUS_IDLE);

  assign araddr  = addr_q;
  assign arprot  = ifu_bus_pkg::ARPROT_INST;
  assign arvalid = (state == ifu_bus_pkg::IBUS_ADDR);
  assign rready  = (state == ifu_bus_pkg::IBUS_DATA);

  // Data of a flushed transaction is taken off the bus and dropped
  assign resp_vld  = rready && rvalid && !discard_q;
  assign resp_data = rdata;
  assign resp_addr = addr_q;
  assign resp_err  = (rresp == ifu_bus_pkg::SLVERR) || (rresp == ifu_bus_pkg::DECERR);

endmodule

`default_nettype wire

// File: rtl/ifu_ifctrl.sv
/*
 * Fetch control
 * Sequential fetch address and request generation, redirected on flush
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_ifctrl (
  input  logic                 forever_cpuclk,
  input  logic                 rst,
  input  logic                 iu_yy_xx_flush,
  input  ifu_pkg::fetch_addr_t iu_ifu_addr,
  input  logic                 ibuf_room,
  input  logic                 fetch_ack,
  output logic                 fetch_req,
  output ifu_pkg::fetch_addr_t fetch_addr
);

  ifu_pkg::fetch_addr_t addr_q;
  logic                 fetch_on;
  logic                 fetch_acc;

  // ====================================================================
  // Request
  // ====================================================================

  // Fetching starts the cycle after reset releases
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      fetch_on <= 1'b0;
    end else begin
      fetch_on <= 1'b1;
    end
  end

  assign fetch_req = fetch_on && ibuf_room && !iu_yy_xx_flush;
  assign fetch_acc = fetch_req && fetch_ack;

  // ====================================================================
  // Fetch address
  // ====================================================================
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      addr_q <= ifu_pkg::RST_ADDR;
    end else if (iu_yy_xx_flush) begin
      // Redirect target, forced onto a word boundary
      addr_q <= {iu_ifu_addr[ifu_pkg::ADDR_W-1:2], 2'b00};
    end else if (fetch_acc) begin
      addr_q <= addr_q + ifu_pkg::fetch_addr_t'(ifu_pkg::INST_BYTES);
    end
  end

  // Held stable until the bus interface takes it
  assign fetch_addr = addr_q;

endmodule

`default_nettype wire

// File: rtl/ifu_ifdp.sv
/*
 * Fetch datapath stage
 * Output register towards the execute unit with stall hold and flush kill
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_ifdp (
  input  logic                 forever_cpuclk,
  input  logic                 rst,
  input  logic                 iu_yy_xx_flush,
  input  logic                 iu_ifu_ex_stall,
  input  logic                 ibuf_vld,
  input  ifu_pkg::inst_t       ibuf_inst,
  input  ifu_pkg::fetch_addr_t ibuf_addr,
  input  logic                 ibuf_err,
  output logic                 pop,
  output ifu_pkg::inst_t       ifu_iu_ex_inst,
  output ifu_pkg::fetch_addr_t ifu_iu_ex_addr,
  output logic                 ifu_iu_ex_inst_vld,
  output logic                 ifu_iu_ex_expt_vld
);

  ifu_pkg::inst_t       inst_q;
  ifu_pkg::fetch_addr_t addr_q;
  logic                 err_q;
  logic                 vld_q;
  logic                 load_ok;

  // Register free, or its instruction leaves this cycle
  assign load_ok = !vld_q || !iu_ifu_ex_stall;
  assign pop     = load_ok && ibuf_vld && !iu_yy_xx_flush;

  always_ff @(posedge forever_cpuclk) begin
    if (rst || iu_yy_xx_flush) begin
      vld_q <= 1'b0;
    end else if (load_ok) begin
      vld_q <= ibuf_vld;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (pop) begin
      inst_q <= ibuf_inst;
      addr_q <= ibuf_addr;
      err_q  <= ibuf_err;
    end
  end

  assign ifu_iu_ex_inst     = inst_q;
  assign ifu_iu_ex_addr     = addr_q;
  assign ifu_iu_ex_inst_vld = vld_q;
  // Fetch exception only counts with a valid instruction
  assign ifu_iu_ex_expt_vld = vld_q && err_q;

endmodule

`default_nettype wire

// File: rtl/ifu_pkg.sv
/*
 * Instruction fetch unit shared definitions
 * Fetch widths, instruction buffer sizing and the reset fetch address
 */
`default_nettype none

package ifu_pkg;

  // ====================================================================
  // Fetch widths
  // ====================================================================
  localparam int ADDR_W     = 32;
  localparam int INST_W     = 32;

  // Word fetch only, so every step is one full instruction
  localparam int INST_BYTES = 4;

  // First fetch after reset
  localparam logic [ADDR_W-1:0] RST_ADDR = 32'h0000_1000;

  // ====================================================================
  // Instruction buffer
  // ====================================================================
  localparam int IBUF_DEPTH = 4;
  localparam int IBUF_PTR_W = 2;

  // ====================================================================
  // Types
  // ====================================================================
  typedef logic [ADDR_W-1:0] fetch_addr_t;
  typedef logic [INST_W-1:0] inst_t;

endpackage

`default_nettype wire

// File: rtl/ifu_top.sv
/*
 * Instruction fetch unit top level
 * Bus interface, buffer, fetch control and output stage
 */
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
  input  logic                   forever_cpuclk,
  input  logic                   rst,
  // AXI4-Lite read channels
  output ifu_pkg::fetch_addr_t   araddr,
  output logic [2:0]             arprot,
  output logic                   arvalid,
  input  logic                   arready,
  input  ifu_pkg::inst_t         rdata,
  input  ifu_bus_pkg::axi_resp_e rresp,
  input  logic                   rvalid,
  output logic                   rready,
  // Execute unit
  input  logic                   iu_ifu_ex_stall,
  input  logic                   iu_yy_xx_flush,
  input  ifu_pkg::fetch_addr_t   iu_ifu_addr,
  output ifu_pkg::inst_t         ifu_iu_ex_inst,
  output ifu_pkg::fetch_addr_t   ifu_iu_ex_addr,
  output logic                   ifu_iu_ex_inst_vld,
  output logic                   ifu_iu_ex_expt_vld,
  output logic                   ifu_iu_ibus_idle
);

  logic                 fetch_req;
  logic                 fetch_ack;
  ifu_pkg::fetch_addr_t fetch_addr;
  logic                 resp_vld;
  ifu_pkg::inst_t       resp_data;
  ifu_pkg::fetch_addr_t resp_addr;
  logic                 resp_err;
  logic                 ibuf_room;
  logic                 ibuf_vld;
  ifu_pkg::inst_t       ibuf_inst;
  ifu_pkg::fetch_addr_t ibuf_addr;
  logic                 ibuf_err;
  logic                 pop;

  // ====================================================================
  // Sub-blocks
  // ====================================================================
  ifu_ibusif x_ibusif (
    .forever_cpuclk   (forever_cpuclk  ),
    .rst              (rst             ),
    .fetch_req        (fetch_req       ),
    .fetch_addr       (fetch_addr      ),
    .iu_yy_xx_flush   (iu_yy_xx_flush  ),
    .arready          (arready         ),
    .rdata            (rdata           ),
    .rresp            (rresp           ),
    .rvalid           (rvalid          ),
    .fetch_ack        (fetch_ack       ),
    .araddr           (araddr          ),
    .arprot           (arprot          ),
    .arvalid          (arvalid         ),
    .rready           (rready          ),
    .resp_vld         (resp_vld        ),
    .resp_data        (resp_data       ),
    .resp_addr        (resp_addr       ),
    .resp_err         (resp_err        ),
    .ifu_iu_ibus_idle (ifu_iu_ibus_idle)
  );

  ifu_ibuf x_ibuf (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst           ),
    .iu_yy_xx_flush (iu_yy_xx_flush),
    .resp_vld       (resp_vld      ),
    .resp_data      (resp_data     ),
    .resp_addr      (resp_addr     ),
    .resp_err       (resp_err      ),
    .pop            (pop           ),
    .ibuf_room      (ibuf_room     ),
    .ibuf_vld       (ibuf_vld      ),
    .ibuf_inst      (ibuf_inst     ),
    .ibuf_addr      (ibuf_addr     ),
    .ibuf_err       (ibuf_err      )
  );

  ifu_ifctrl x_ifctrl (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst           ),
    .iu_yy_xx_flush (iu_yy_xx_flush),
    .iu_ifu_addr    (iu_ifu_addr   ),
    .ibuf_room      (ibuf_room     ),
    .fetch_ack      (fetch_ack     ),
    .fetch_req      (fetch_req     ),
    .fetch_addr     (fetch_addr    )
  );

  ifu_ifdp x_ifdp (
    .forever_cpuclk     (forever_cpuclk    ),
    .rst                (rst               ),
    .iu_yy_xx_flush     (iu_yy_xx_flush    ),
    .iu_ifu_ex_stall    (iu_ifu_ex_stall   ),
    .ibuf_vld           (ibuf_vld          ),
    .ibuf_inst          (ibuf_inst         ),
    .ibuf_addr          (ibuf_addr         ),
    .ibuf_err           (ibuf_err          ),
    .pop                (pop               ),
    .ifu_iu_ex_inst     (ifu_iu_ex_inst    ),
    .ifu_iu_ex_addr     (ifu_iu_ex_addr    ),
    .ifu_iu_ex_inst_vld (ifu_iu_ex_inst_vld),
    .ifu_iu_ex_expt_vld (ifu_iu_ex_expt_vld)
  );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
BIN=sim_ifu_top

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
     --top-module tb_ifu_top -Mdir "$OBJ_DIR" -o "$BIN" -f ifu_top.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$OBJ_DIR/$BIN" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error status"
  exit 1
fi
cat "$LOG"

if grep -qx "Everything OK" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation did not pass, see $LOG"
  exit 1
fi

// File: testbench/tb_ifu_top.sv
/*
 * Testbench for the instruction fetch unit
 * AXI4-Lite memory model with random latency, IU stall and flush traffic
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ifu_top;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int SEQ_COUNT      = 200;
  localparam int FLUSH_COUNT    = 16;

  logic                   forever_cpuclk;
  logic                   rst;
  ifu_pkg::fetch_addr_t   araddr;
  logic [2:0]             arprot;
  logic                   arvalid;
  logic                   arready;
  ifu_pkg::inst_t         rdata;
  ifu_bus_pkg::axi_resp_e rresp;
  logic                   rvalid;
  logic                   rready;
  logic                   iu_ifu_ex_stall;
  logic                   iu_yy_xx_flush;
  ifu_pkg::fetch_addr_t   iu_ifu_addr;
  ifu_pkg::inst_t         ifu_iu_ex_inst;
  ifu_pkg::fetch_addr_t   ifu_iu_ex_addr;
  logic                   ifu_iu_ex_inst_vld;
  logic                   ifu_iu_ex_expt_vld;
  logic                   ifu_iu_ibus_idle;

  integer               seed = 32'h2a71;
  ifu_pkg::fetch_addr_t exp_addr;
  int                   consumed_cnt;
  int                   cycle_cnt = 0;
  logic                 ar_pending;
  logic                 consumed;

  int rst_errs  = 0;
  int addr_errs = 0;
  int data_errs = 0;
  int expt_errs = 0;
  int hold_errs = 0;
  int ar_errs   = 0;
  int prot_errs = 0;
  int ost_errs  = 0;
  int bus_errs  = 0;

  ifu_top u_ifu_top (.*);

  // Memory contents and error region
  function automatic ifu_pkg::inst_t mem_word(input ifu_pkg::fetch_addr_t addr);
    return addr ^ 32'h5a5a_5a5a;
  endfunction

  function automatic logic in_err_region(input ifu_pkg::fetch_addr_t addr);
    return addr[31:28] == 4'hF;
  endfunction

  initial begin
    forever_cpuclk = 1'b0;
    forever #10 forever_cpuclk = ~forever_cpuclk;
  end

  always @(posedge forever_cpuclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // ====================================================================
  // Scoreboard and bus tracking
  // ====================================================================
  // Flush cycles never count as consumption
  assign consumed = ifu_iu_ex_inst_vld && !iu_ifu_ex_stall && !iu_yy_xx_flush;

  always @(posedge forever_cpuclk) begin
    if (rst) begin
      exp_addr     <= ifu_pkg::RST_ADDR;
      consumed_cnt <= 0;
    end else if (iu_yy_xx_flush) begin
      exp_addr <= iu_ifu_addr;
    end else if (consumed) begin
      exp_addr     <= exp_addr + 32'd4;
      consumed_cnt <= consumed_cnt + 1;
    end
  end

  // Address accepted and data not yet returned
  always @(posedge forever_cpuclk) begin
    if (rst) begin
      ar_pending <= 1'b0;
    end else if (arvalid && arready) begin
      ar_pending <= 1'b1;
    end else if (rvalid && rready) begin
      ar_pending <= 1'b0;
    end
  end

  // ====================================================================
  // Checkers
  // ====================================================================
  chk_reset_state: assert property (@(posedge forever_cpuclk)
      rst |=> (!arvalid && !ifu_iu_ex_inst_vld && ifu_iu_ibus_idle))
    else begin
      rst_errs = rst_errs + 1;
      $display("ERR %0t: outputs not in reset state", $time);
    end

  chk_addr: assert property (@(posedge forever_cpuclk) disable iff (rst)
      consumed |-> (ifu_iu_ex_addr == exp_addr))
    else begin
      addr_errs = addr_errs + 1;
      $display("ERR %0t: consumed address %h, expected %h", $time,
               $sampled(ifu_iu_ex_addr), $sampled(exp_addr));
    end

  chk_data: assert property (@(posedge forever_cpuclk) disable iff (rst)
      consumed |-> (ifu_iu_ex_inst == mem_word(ifu_iu_ex_addr)))
    else begin
      data_errs = data_errs + 1;
      $display("ERR %0t: wrong instruction %h at address %h", $time,
               $sampled(ifu_iu_ex_inst), $sampled(ifu_iu_ex_addr));
    end

  chk_expt: assert property (@(posedge forever_cpuclk) disable iff (rst)
      consumed |-> (ifu_iu_ex_expt_vld == in_err_region(ifu_iu_ex_addr)))
    else begin
      expt_errs = expt_errs + 1;
      $display("ERR %0t: fetch exception flag wrong at address %h", $time,
               $sampled(ifu_iu_ex_addr));
    end

  chk_stall_hold: assert property (@(posedge forever_cpuclk) disable iff (rst)
      (ifu_iu_ex_inst_vld && iu_ifu_ex_stall && !iu_yy_xx_flush) |=>
      (ifu_iu_ex_inst_vld && $stable(ifu_iu_ex_inst) && $stable(ifu_iu_ex_addr)
       && $stable(ifu_iu_ex_expt_vld)))
    else begin
      hold_errs = hold_errs + 1;
      $display("ERR %0t: output changed under stall", $time);
    end

  chk_ar_stable: assert property (@(posedge forever_cpuclk) disable iff (rst)
      (arvalid && !arready) |=> (arvalid && $stable(araddr)))
    else begin
      ar_errs = ar_errs + 1;
      $display("ERR %0t: arvalid or araddr changed before arready", $time);
    end

  chk_arprot: assert property (@(posedge forever_cpuclk) disable iff (rst)
      arprot == ifu_bus_pkg::ARPROT_INST)
    else begin
      prot_errs = prot_errs + 1;
      $display("ERR %0t: arprot %b", $time, $sampled(arprot));
    end

  chk_one_outstanding: assert property (@(posedge forever_cpuclk) disable iff (rst)
      ar_pending |-> !arvalid)
    else begin
      ost_errs = ost_errs + 1;
      $display("ERR %0t: second read address while data pending", $time);
    end

  // Data phase owns rready, and the bus is idle only with nothing in flight
  chk_bus_phase: assert property (@(posedge forever_cpuclk) disable iff (rst)
      (rready == ar_pending) && (ifu_iu_ibus_idle == (!arvalid && !ar_pending)))
    else begin
      bus_errs = bus_errs + 1;
      $display("ERR %0t: rready %b or bus idle %b wrong for the bus phase", $time,
               $sampled(rready), $sampled(ifu_iu_ibus_idle));
    end

  // ====================================================================
  // AXI4-Lite memory model
  // ====================================================================
  initial begin : mem_model
    int                   delay;
    ifu_pkg::fetch_addr_t req_addr;
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = ifu_bus_pkg::OKAY;
    forever begin
      @(negedge forever_cpuclk);
      if (arvalid && !rst) begin
        delay = $random(seed) & 3;
        repeat (delay) @(negedge forever_cpuclk);
        arready  = 1'b1;
        req_addr = araddr;
        @(negedge forever_cpuclk);
        arready = 1'b0;
        delay   = $random(seed) & 3;
        repeat (delay) @(negedge forever_cpuclk);
        rvalid = 1'b1;
        rdata  = mem_word(req_addr);
        if (in_err_region(req_addr)) begin
          rresp = ifu_bus_pkg::SLVERR;
        end else begin
          rresp = ifu_bus_pkg::OKAY;
        end
        @(negedge forever_cpuclk);
        rvalid = 1'b0;
        rresp  = ifu_bus_pkg::OKAY;
      end
    end
  end

  // ====================================================================
  // IU stimulus
  // ====================================================================
  task automatic run_with_random_stall(input int n);
    int goal;
    goal = consumed_cnt + n;
    while (consumed_cnt < goal) begin
      @(negedge forever_cpuclk);
      iu_ifu_ex_stall = (($random(seed) & 3) == 0);
    end
  endtask

  // Long stall so the buffer fills and requests stop
  task automatic hold_stall(input int cycles);
    @(negedge forever_cpuclk);
    iu_ifu_ex_stall = 1'b1;
    repeat (cycles) @(negedge forever_cpuclk);
  endtask

  task automatic flush_to(input ifu_pkg::fetch_addr_t target);
    @(negedge forever_cpuclk);
    iu_ifu_ex_stall = 1'b1;
    iu_yy_xx_flush  = 1'b1;
    iu_ifu_addr     = target;
    @(negedge forever_cpuclk);
    iu_yy_xx_flush  = 1'b0;
  endtask

  initial begin : stimulus
    int total;
    rst             = 1'b1;
    iu_ifu_ex_stall = 1'b0;
    iu_yy_xx_flush  = 1'b0;
    iu_ifu_addr     = '0;
    repeat (8) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    rst = 1'b0;

    // Sequential fetch from the reset address
    run_with_random_stall(SEQ_COUNT / 2);
    hold_stall(30);
    run_with_random_stall(SEQ_COUNT / 2);

    // Redirects with two of them into the error region
    flush_to(32'h0000_2000);
    run_with_random_stall(FLUSH_COUNT);
    flush_to($random(seed) & 32'h7fff_fffc);
    run_with_random_stall(FLUSH_COUNT);
    flush_to(32'hf000_0100);
    run_with_random_stall(FLUSH_COUNT);
    flush_to(32'hefff_fff0);
    run_with_random_stall(FLUSH_COUNT);
    flush_to($random(seed) & 32'h7fff_fffc);
    run_with_random_stall(FLUSH_COUNT);
    // Two redirects in a row where only the second one reaches the IU
    flush_to(32'h0000_3000);
    flush_to(32'h0000_4000);
    run_with_random_stall(FLUSH_COUNT);

    iu_ifu_ex_stall = 1'b0;
    repeat (4) @(negedge forever_cpuclk);

    total = rst_errs + addr_errs + data_errs + expt_errs + hold_errs
          + ar_errs + prot_errs + ost_errs + bus_errs;
    $write("Done %0d, errs rst %0d adr %0d dat %0d exc %0d hld %0d ",
           consumed_cnt, rst_errs, addr_errs, data_errs, expt_errs, hold_errs);
    $display("ar %0d prt %0d ost %0d bus %0d", ar_errs, prot_errs, ost_errs, bus_errs);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
